// ==== list.f ====
source/isaPkg.sv
source/ctrlPkg.sv
source/instrDecoder.sv
source/controlSequencer.sv
source/controlSignalGen.sv
source/controlUnit.sv
verif/tbClock.sv
verif/controlUnit_props.sv
verif/controlUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controlUnit_tb -f list.f -o simControlUnit

result=$(./obj_dir/simControlUnit 2>&1) || true
echo "$result"

if echo "$result" | grep -qx "Regression passed"; then
	exit 0
else
	exit 1
fi

// ==== source/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
	input logic clk,
	input logic Reset,
	input logic Overflow,
	input isaPkg::opClassT opClass,
	output ctrlPkg::stateT state
);

	ctrlPkg::stateT nextState;
	ctrlPkg::stateT routedState;
	logic overflowChecked;

	always_ff @(posedge clk or posedge Reset) begin
		if (Reset) begin
			state <= ctrlPkg::fetchStart;
		end else begin
			state <= nextState;
		end
	end

	// states whose ALU result can overflow
	always_comb begin
		case (state)
			ctrlPkg::fetchIncr,
			ctrlPkg::calcOffset,
			ctrlPkg::addReg,
			ctrlPkg::subReg,
			ctrlPkg::andReg,
			ctrlPkg::sltReg,
			ctrlPkg::sltiImm,
			ctrlPkg::branchEq,
			ctrlPkg::branchNe,
			ctrlPkg::branchLt,
			ctrlPkg::branchGe,
			ctrlPkg::jalrCalc: overflowChecked = 1'b1;
			default: overflowChecked = 1'b0;
		endcase
	end

	always_comb begin
		routedState = ctrlPkg::fetchStart;
		case (state)
			ctrlPkg::fetchStart: routedState = ctrlPkg::fetchIncr;
			ctrlPkg::fetchIncr: routedState = ctrlPkg::decode;
			ctrlPkg::decode: begin
				case (opClass)
					isaPkg::clsAdd: routedState = ctrlPkg::addReg;
					isaPkg::clsSub: routedState = ctrlPkg::subReg;
					isaPkg::clsAnd: routedState = ctrlPkg::andReg;
					isaPkg::clsSlt: routedState = ctrlPkg::sltReg;
					isaPkg::clsSlti: routedState = ctrlPkg::sltiImm;
					isaPkg::clsAddi,
					isaPkg::clsLoad,
					isaPkg::clsStore: routedState = ctrlPkg::calcOffset;
					isaPkg::clsLui: routedState = ctrlPkg::luiWrite;
					isaPkg::clsBeq: routedState = ctrlPkg::branchEq;
					isaPkg::clsBne: routedState = ctrlPkg::branchNe;
					isaPkg::clsBlt: routedState = ctrlPkg::branchLt;
					isaPkg::clsBge: routedState = ctrlPkg::branchGe;
					isaPkg::clsJal,
					isaPkg::clsJalr: routedState = ctrlPkg::jumpLink;
					isaPkg::clsNop: routedState = ctrlPkg::fetchStart;
					isaPkg::clsBreak: routedState = ctrlPkg::halted;
					default: routedState = ctrlPkg::illegalTrap;
				endcase
			end
			ctrlPkg::calcOffset: begin
				case (opClass)
					isaPkg::clsAddi: routedState = ctrlPkg::writeAlu;
					isaPkg::clsLoad,
					isaPkg::clsStore: routedState = ctrlPkg::memRead;
					default: routedState = ctrlPkg::illegalTrap;
				endcase
			end
			ctrlPkg::addReg,
			ctrlPkg::subReg,
			ctrlPkg::andReg: routedState = ctrlPkg::writeAlu;
			ctrlPkg::memRead: routedState = ctrlPkg::memWait;
			ctrlPkg::memWait: begin
				case (opClass)
					isaPkg::clsLoad: routedState = ctrlPkg::loadWrite;
					isaPkg::clsStore: routedState = ctrlPkg::memWrite;
					default: routedState = ctrlPkg::illegalTrap;
				endcase
			end
			ctrlPkg::branchEq,
			ctrlPkg::branchNe,
			ctrlPkg::branchLt,
			ctrlPkg::branchGe: routedState = ctrlPkg::branchWait;
			ctrlPkg::jumpLink: begin
				if (opClass == isaPkg::clsJalr) begin
					routedState = ctrlPkg::jalrLoadReg;
				end else begin
					routedState = ctrlPkg::jumpTarget;
				end
			end
			ctrlPkg::jalrLoadReg: routedState = ctrlPkg::jalrCalc;
			ctrlPkg::jalrCalc: routedState = ctrlPkg::jumpTarget;
			ctrlPkg::jumpTarget: routedState = ctrlPkg::branchWait;
			ctrlPkg::illegalTrap,
			ctrlPkg::overflowTrap: routedState = ctrlPkg::trapEnd;
			ctrlPkg::halted: routedState = ctrlPkg::halted; // only reset leaves
			default: routedState = ctrlPkg::fetchStart;
		endcase
	end

	assign nextState = (overflowChecked && Overflow) ? ctrlPkg::overflowTrap : routedState;

endmodule

`default_nettype wire

// ==== source/controlSignalGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSignalGen (
	input ctrlPkg::stateT state,
	output ctrlPkg::pcSrcT PCSrc,
	output ctrlPkg::aluFunctT ALUFunct,
	output logic ALUSrcA,
	output ctrlPkg::aluSrcBT ALUSrcB,
	output ctrlPkg::memToRegT MemToReg,
	output ctrlPkg::branchOpT BranchOp,
	output ctrlPkg::excSrcT SrcExc,
	output logic PCWrite,
	output logic PCWriteCond,
	output logic LoadRegA,
	output logic LoadRegB,
	output logic LoadALUOut,
	output logic WriteReg,
	output logic LoadIR,
	output logic DMemWrite,
	output logic LoadMDR,
	output logic LoadExc
);

	always_comb begin
		PCSrc = ctrlPkg::pcAlu;
		ALUFunct = ctrlPkg::aluPass;
		ALUSrcA = 1'b0; // pc
		ALUSrcB = ctrlPkg::srcBReg;
		MemToReg = ctrlPkg::wbAluOut;
		BranchOp = ctrlPkg::brEq;
		SrcExc = ctrlPkg::excNone;
		PCWrite = 1'b0;
		PCWriteCond = 1'b0;
		LoadRegA = 1'b0;
		LoadRegB = 1'b0;
		LoadALUOut = 1'b0;
		WriteReg = 1'b0;
		LoadIR = 1'b0;
		DMemWrite = 1'b0;
		LoadMDR = 1'b0;
		LoadExc = 1'b0;
		case (state)
			ctrlPkg::fetchStart: LoadIR = 1'b1;
			ctrlPkg::fetchIncr: begin
				ALUFunct = ctrlPkg::aluAdd; // pc + 4
				ALUSrcB = ctrlPkg::srcBFour;
				PCWrite = 1'b1;
			end
			ctrlPkg::decode: begin
				LoadRegA = 1'b1;
				LoadRegB = 1'b1;
				ALUFunct = ctrlPkg::aluAdd; // branch target ahead of time
				ALUSrcB = ctrlPkg::srcBBranchImm;
				LoadALUOut = 1'b1;
			end
			ctrlPkg::calcOffset,
			ctrlPkg::jalrCalc: begin
				ALUFunct = ctrlPkg::aluAdd;
				ALUSrcA = 1'b1;
				ALUSrcB = ctrlPkg::srcBImm;
				LoadALUOut = 1'b1;
			end
			ctrlPkg::addReg,
			ctrlPkg::subReg,
			ctrlPkg::andReg: begin
				ALUFunct = (state == ctrlPkg::subReg) ? ctrlPkg::aluSub :
					(state == ctrlPkg::andReg) ? ctrlPkg::aluAnd : ctrlPkg::aluAdd;
				ALUSrcA = 1'b1;
				LoadALUOut = 1'b1;
			end
			ctrlPkg::sltReg,
			ctrlPkg::sltiImm: begin
				ALUFunct = ctrlPkg::aluSub; // sign of a - b
				ALUSrcA = 1'b1;
				ALUSrcB = (state == ctrlPkg::sltiImm) ? ctrlPkg::srcBImm : ctrlPkg::srcBReg;
				MemToReg = ctrlPkg::wbLessThan;
				WriteReg = 1'b1;
			end
			ctrlPkg::writeAlu: WriteReg = 1'b1;
			ctrlPkg::memWait: LoadMDR = 1'b1; // read data valid one cycle after address
			ctrlPkg::memWrite: DMemWrite = 1'b1;
			ctrlPkg::loadWrite: begin
				MemToReg = ctrlPkg::wbMdr;
				WriteReg = 1'b1;
			end
			ctrlPkg::luiWrite: begin
				MemToReg = ctrlPkg::wbLui;
				WriteReg = 1'b1;
			end
			ctrlPkg::branchEq,
			ctrlPkg::branchNe,
			ctrlPkg::branchLt,
			ctrlPkg::branchGe: begin
				ALUFunct = ctrlPkg::aluSub;
				ALUSrcA = 1'b1;
				PCSrc = ctrlPkg::pcAluOut; // target from decode
				PCWriteCond = 1'b1;
				case (state)
					ctrlPkg::branchNe: BranchOp = ctrlPkg::brNe;
					ctrlPkg::branchLt: BranchOp = ctrlPkg::brLt;
					ctrlPkg::branchGe: BranchOp = ctrlPkg::brGe;
					default: BranchOp = ctrlPkg::brEq;
				endcase
			end
			ctrlPkg::jumpLink: begin
				MemToReg = ctrlPkg::wbPc; // return address
				WriteReg = 1'b1;
			end
			ctrlPkg::jumpTarget: begin
				PCSrc = ctrlPkg::pcAluOut;
				PCWrite = 1'b1;
			end
			ctrlPkg::jalrLoadReg: LoadRegA = 1'b1;
			ctrlPkg::illegalTrap,
			ctrlPkg::overflowTrap: begin
				ALUFunct = ctrlPkg::aluSub; // back to the faulting pc
				ALUSrcB = ctrlPkg::srcBFour;
				LoadExc = 1'b1;
				SrcExc = (state == ctrlPkg::overflowTrap) ? ctrlPkg::excOverflow :
					ctrlPkg::excIllegal;
			end
			ctrlPkg::trapEnd: begin
				PCSrc = ctrlPkg::pcExcVector;
				PCWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic clk,
	input logic Reset,
	input logic Overflow,
	input logic [isaPkg::instrWidth-1:0] instruction,
	output ctrlPkg::stateT state,
	output ctrlPkg::pcSrcT PCSrc,
	output ctrlPkg::aluFunctT ALUFunct,
	output logic ALUSrcA,
	output ctrlPkg::aluSrcBT ALUSrcB,
	output ctrlPkg::memToRegT MemToReg,
	output ctrlPkg::branchOpT BranchOp,
	output ctrlPkg::excSrcT SrcExc,
	output logic PCWrite,
	output logic PCWriteCond,
	output logic LoadRegA,
	output logic LoadRegB,
	output logic LoadALUOut,
	output logic WriteReg,
	output logic LoadIR,
	output logic DMemWrite,
	output logic LoadMDR,
	output logic LoadExc
);

	isaPkg::opClassT opClass;

	instrDecoder i_instrDecoder (
		.instruction(instruction),
		.opClass(opClass)
	);

	controlSequencer i_controlSequencer (
		.clk(clk),
		.Reset(Reset),
		.Overflow(Overflow),
		.opClass(opClass),
		.state(state)
	);

	controlSignalGen i_controlSignalGen (
		.state(state),
		.PCSrc(PCSrc),
		.ALUFunct(ALUFunct),
		.ALUSrcA(ALUSrcA),
		.ALUSrcB(ALUSrcB),
		.MemToReg(MemToReg),
		.BranchOp(BranchOp),
		.SrcExc(SrcExc),
		.PCWrite(PCWrite),
		.PCWriteCond(PCWriteCond),
		.LoadRegA(LoadRegA),
		.LoadRegB(LoadRegB),
		.LoadALUOut(LoadALUOut),
		.WriteReg(WriteReg),
		.LoadIR(LoadIR),
		.DMemWrite(DMemWrite),
		.LoadMDR(LoadMDR),
		.LoadExc(LoadExc)
	);

endmodule

`default_nettype wire

// ==== source/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

	typedef enum logic [5:0] {
		fetchStart,
		fetchIncr,
		decode,
		calcOffset,
		addReg,
		subReg,
		andReg,
		sltReg,
		sltiImm,
		writeAlu,
		memRead,
		memWait,
		memWrite,
		loadWrite,
		luiWrite,
		branchEq,
		branchNe,
		branchLt,
		branchGe,
		branchWait,
		jumpLink,
		jumpTarget,
		jalrLoadReg,
		jalrCalc,
		illegalTrap,
		overflowTrap,
		trapEnd,
		halted
	} stateT;

	typedef enum logic [2:0] {
		aluPass = 3'b000,
		aluAdd  = 3'b001,
		aluSub  = 3'b010,
		aluAnd  = 3'b011
	} aluFunctT;

	typedef enum logic [1:0] {
		pcAlu       = 2'b00,
		pcAluOut    = 2'b01,
		pcExcVector = 2'b10
	} pcSrcT;

	typedef enum logic [1:0] {
		srcBReg       = 2'b00,
		srcBFour      = 2'b01,
		srcBImm       = 2'b10,
		srcBBranchImm = 2'b11
	} aluSrcBT;

	typedef enum logic [2:0] {
		wbAluOut   = 3'b000,
		wbMdr      = 3'b001,
		wbLui      = 3'b010,
		wbPc       = 3'b011,
		wbLessThan = 3'b101 // 3'b100 left unused
	} memToRegT;

	typedef enum logic [1:0] {
		brEq = 2'b00,
		brNe = 2'b01,
		brGe = 2'b10,
		brLt = 2'b11
	} branchOpT;

	typedef enum logic [1:0] {
		excNone     = 2'b00,
		excIllegal  = 2'b01,
		excOverflow = 2'b10
	} excSrcT;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input logic [isaPkg::instrWidth-1:0] instruction,
	output isaPkg::opClassT opClass
);

	isaPkg::opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd;

	assign opcode = isaPkg::opcodeT'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign rd = instruction[11:7];

	always_comb begin
		opClass = isaPkg::clsIllegal;
		case (opcode)
			isaPkg::opRegType: begin
				if (funct7 == isaPkg::funct7Sub && funct3 == isaPkg::funct3Add) begin
					opClass = isaPkg::clsSub;
				end else if (funct7 == isaPkg::funct7Add) begin
					case (funct3)
						isaPkg::funct3Add: opClass = isaPkg::clsAdd;
						isaPkg::funct3And: opClass = isaPkg::clsAnd;
						isaPkg::funct3Slt: opClass = isaPkg::clsSlt;
						default: opClass = isaPkg::clsIllegal;
					endcase
				end
			end
			isaPkg::opImm: begin
				if (rd == isaPkg::regZero) begin
					opClass = isaPkg::clsNop; // any write to x0 is dropped
				end else begin
					case (funct3)
						isaPkg::funct3Add: opClass = isaPkg::clsAddi;
						isaPkg::funct3Slt: opClass = isaPkg::clsSlti;
						default: opClass = isaPkg::clsIllegal; // shifts included
					endcase
				end
			end
			isaPkg::opBranch: begin
				case (funct3)
					isaPkg::funct3Jalr: opClass = isaPkg::clsJalr;
					isaPkg::funct3Bne: opClass = isaPkg::clsBne;
					isaPkg::funct3Blt: opClass = isaPkg::clsBlt;
					isaPkg::funct3Bge: opClass = isaPkg::clsBge;
					default: opClass = isaPkg::clsIllegal;
				endcase
			end
			isaPkg::opBranchEq: opClass = isaPkg::clsBeq;
			isaPkg::opLoad: opClass = isaPkg::clsLoad;
			isaPkg::opStore: opClass = isaPkg::clsStore;
			isaPkg::opLui: opClass = isaPkg::clsLui;
			isaPkg::opJal: opClass = isaPkg::clsJal;
			isaPkg::opSystem: opClass = isaPkg::clsBreak;
			default: opClass = isaPkg::clsIllegal;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/isaPkg.sv ====
`default_nettype none

package isaPkg;

	parameter int instrWidth = 32;

	// major opcodes, instruction bits [6:0]
	typedef enum logic [6:0] {
		opRegType  = 7'b0110011,
		opStore    = 7'b0100011,
		opBranch   = 7'b1100111, // jalr, bne, blt, bge
		opBranchEq = 7'b1100011,
		opImm      = 7'b0010011,
		opLoad     = 7'b0000011,
		opLui      = 7'b0110111,
		opSystem   = 7'b1110011,
		opJal      = 7'b1101111
	} opcodeT;

	parameter logic [6:0] funct7Add = 7'b0000000;
	parameter logic [6:0] funct7Sub = 7'b0100000;

	parameter logic [2:0] funct3Add  = 3'b000; // also addi
	parameter logic [2:0] funct3Slt  = 3'b010; // also slti
	parameter logic [2:0] funct3And  = 3'b111;
	parameter logic [2:0] funct3Jalr = 3'b000;
	parameter logic [2:0] funct3Bne  = 3'b001;
	parameter logic [2:0] funct3Blt  = 3'b100;
	parameter logic [2:0] funct3Bge  = 3'b101;

	parameter logic [4:0] regZero = 5'd0;

	typedef enum logic [4:0] {
		clsAdd,
		clsSub,
		clsAnd,
		clsSlt,
		clsAddi,
		clsSlti,
		clsNop,
		clsLoad,
		clsStore,
		clsLui,
		clsBeq,
		clsBne,
		clsBlt,
		clsBge,
		clsJal,
		clsJalr,
		clsBreak,
		clsIllegal
	} opClassT;

endpackage

`default_nettype wire

// ==== verif/controlUnit_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit_props (
	input logic clk,
	input logic Reset,
	input logic Overflow,
	input ctrlPkg::stateT state,
	input logic PCWrite,
	input logic PCWriteCond,
	input logic WriteReg,
	input logic LoadIR,
	input logic DMemWrite
);

	dmemOnlyInWrite: assert property (@(posedge clk) disable iff (Reset)
		DMemWrite |-> state == ctrlPkg::memWrite)
		else $error("DMemWrite outside memWrite");

	irLoadOnlyInFetch: assert property (@(posedge clk)
		LoadIR == (state == ctrlPkg::fetchStart))
		else $error("LoadIR does not follow fetchStart");

	pcWriteExclusive: assert property (@(posedge clk) disable iff (Reset)
		!(PCWrite && PCWriteCond))
		else $error("PCWrite and PCWriteCond together");

	memReadToWait: assert property (@(posedge clk) disable iff (Reset)
		state == ctrlPkg::memRead |=> state == ctrlPkg::memWait)
		else $error("memRead not followed by memWait");

	// halted is left only through reset
	haltHolds: assert property (@(posedge clk) disable iff (Reset)
		state == ctrlPkg::halted |=> state == ctrlPkg::halted && !WriteReg && !DMemWrite)
		else $error("halted state was left or strobed");

	addOverflowTraps: assert property (@(posedge clk) disable iff (Reset)
		state == ctrlPkg::addReg && Overflow |=> state == ctrlPkg::overflowTrap)
		else $error("overflow in addReg did not trap");

	writeAluIgnoresOverflow: assert property (@(posedge clk) disable iff (Reset)
		state == ctrlPkg::writeAlu |=> state == ctrlPkg::fetchStart)
		else $error("writeAlu did not return to fetchStart");

	trapsReachEnd: assert property (@(posedge clk) disable iff (Reset)
		state == ctrlPkg::illegalTrap || state == ctrlPkg::overflowTrap
		|=> state == ctrlPkg::trapEnd)
		else $error("trap state not followed by trapEnd");

endmodule

bind controlUnit controlUnit_props i_controlUnit_props (.*);

`default_nettype wire

// ==== verif/controlUnit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit_tb;

	localparam int maxCycles = 3000;

	logic clk;
	logic Reset;
	logic resetReq;
	logic Overflow;
	logic [isaPkg::instrWidth-1:0] instruction;
	ctrlPkg::stateT state;
	ctrlPkg::pcSrcT PCSrc;
	ctrlPkg::aluFunctT ALUFunct;
	logic ALUSrcA;
	ctrlPkg::aluSrcBT ALUSrcB;
	ctrlPkg::memToRegT MemToReg;
	ctrlPkg::branchOpT BranchOp;
	ctrlPkg::excSrcT SrcExc;
	logic PCWrite;
	logic PCWriteCond;
	logic LoadRegA;
	logic LoadRegB;
	logic LoadALUOut;
	logic WriteReg;
	logic LoadIR;
	logic DMemWrite;
	logic LoadMDR;
	logic LoadExc;
	ctrlPkg::stateT expSeq[$]; // expected states of one instruction
	int cycleCount = 0;
	int writeCount;
	int storeCount;

	tbClock #(.periodNs(40), .resetCycles(8)) i_tbClock (
		.resetReq(resetReq),
		.clk(clk),
		.Reset(Reset)
	);

	controlUnit i_controlUnit (.*);

	task automatic failCheck(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("Timeout: run did not finish within %0d cycles", maxCycles);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [4:0] newRd();
		return 5'($urandom_range(31, 1));
	endfunction

	function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [6:0] op);
		logic [4:0] rs1;
		logic [4:0] rs2;
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	// strobes and selects that each state must show
	task automatic checkOutputs(input ctrlPkg::stateT s);
		logic others;
		others = PCWrite | PCWriteCond | LoadRegA | LoadRegB | LoadALUOut | WriteReg |
			DMemWrite | LoadMDR | LoadExc;
		assert (state == s)
			else failCheck($sformatf("state %s, expected %s", state.name(), s.name()));
		case (s)
			ctrlPkg::fetchStart: assert (LoadIR && !others)
				else failCheck("fetchStart strobes wrong");
			ctrlPkg::fetchIncr: assert (PCWrite && ALUFunct == ctrlPkg::aluAdd && !ALUSrcA &&
					ALUSrcB == ctrlPkg::srcBFour)
				else failCheck("pc increment controls wrong");
			ctrlPkg::decode: assert (LoadRegA && LoadRegB && LoadALUOut)
				else failCheck("decode register loads missing");
			ctrlPkg::calcOffset: assert (LoadALUOut && ALUFunct == ctrlPkg::aluAdd && ALUSrcA &&
					ALUSrcB == ctrlPkg::srcBImm)
				else failCheck("offset calculation controls wrong");
			ctrlPkg::addReg: assert (LoadALUOut && ALUFunct == ctrlPkg::aluAdd && ALUSrcA &&
					ALUSrcB == ctrlPkg::srcBReg)
				else failCheck("add controls wrong");
			ctrlPkg::subReg: assert (LoadALUOut && ALUFunct == ctrlPkg::aluSub && ALUSrcA &&
					ALUSrcB == ctrlPkg::srcBReg)
				else failCheck("sub controls wrong");
			ctrlPkg::andReg: assert (LoadALUOut && ALUFunct == ctrlPkg::aluAnd && ALUSrcA &&
					ALUSrcB == ctrlPkg::srcBReg)
				else failCheck("and controls wrong");
			ctrlPkg::memWait: assert (LoadMDR) else failCheck("LoadMDR missing");
			ctrlPkg::halted: assert (!LoadIR && !others)
				else failCheck("strobe active while halted");
			ctrlPkg::writeAlu,
			ctrlPkg::luiWrite: assert (WriteReg) else failCheck("WriteReg missing");
			ctrlPkg::sltReg,
			ctrlPkg::sltiImm: assert (WriteReg && MemToReg == ctrlPkg::wbLessThan)
				else failCheck("slt write-back wrong");
			ctrlPkg::loadWrite: assert (WriteReg && MemToReg == ctrlPkg::wbMdr)
				else failCheck("load write-back wrong");
			ctrlPkg::memWrite: assert (DMemWrite) else failCheck("DMemWrite missing");
			ctrlPkg::branchEq: assert (PCWriteCond && BranchOp == ctrlPkg::brEq)
				else failCheck("beq branch control wrong");
			ctrlPkg::branchNe: assert (PCWriteCond && BranchOp == ctrlPkg::brNe)
				else failCheck("bne branch control wrong");
			ctrlPkg::branchLt: assert (PCWriteCond && BranchOp == ctrlPkg::brLt)
				else failCheck("blt branch control wrong");
			ctrlPkg::branchGe: assert (PCWriteCond && BranchOp == ctrlPkg::brGe)
				else failCheck("bge branch control wrong");
			ctrlPkg::jumpLink: assert (WriteReg && MemToReg == ctrlPkg::wbPc)
				else failCheck("link write-back wrong");
			ctrlPkg::jumpTarget: assert (PCWrite && PCSrc == ctrlPkg::pcAluOut)
				else failCheck("jump target write wrong");
			ctrlPkg::illegalTrap: assert (LoadExc && SrcExc == ctrlPkg::excIllegal)
				else failCheck("illegal trap cause wrong");
			ctrlPkg::overflowTrap: assert (LoadExc && SrcExc == ctrlPkg::excOverflow)
				else failCheck("overflow trap cause wrong");
			ctrlPkg::trapEnd: assert (PCWrite && PCSrc == ctrlPkg::pcExcVector)
				else failCheck("exception vector jump wrong");
			default: begin
			end
		endcase
	endtask

	task automatic planSeq(input int n, input ctrlPkg::stateT s0,
			input ctrlPkg::stateT s1 = ctrlPkg::fetchStart,
			input ctrlPkg::stateT s2 = ctrlPkg::fetchStart,
			input ctrlPkg::stateT s3 = ctrlPkg::fetchStart,
			input ctrlPkg::stateT s4 = ctrlPkg::fetchStart,
			input ctrlPkg::stateT s5 = ctrlPkg::fetchStart);
		ctrlPkg::stateT given[6];
		given = '{s0, s1, s2, s3, s4, s5};
		expSeq.delete();
		expSeq.push_back(ctrlPkg::fetchStart);
		expSeq.push_back(ctrlPkg::fetchIncr);
		for (int i = 0; i < n; i++) begin
			expSeq.push_back(given[i]);
		end
	endtask

	// called 2 ns after the edge that starts a fetchStart cycle
	task automatic runInstr(input logic [31:0] instr, input int expWrites, input int expStores,
			input ctrlPkg::stateT ovfState = ctrlPkg::fetchStart, input logic ovfOn = 1'b0);
		writeCount = 0;
		storeCount = 0;
		instruction = instr;
		foreach (expSeq[i]) begin
			Overflow = ovfOn && (expSeq[i] == ovfState);
			@(negedge clk);
			checkOutputs(expSeq[i]);
			if (WriteReg) writeCount++;
			if (DMemWrite) storeCount++;
			@(posedge clk);
			#2;
		end
		Overflow = 1'b0;
		assert (state == ctrlPkg::fetchStart || expSeq[$] == ctrlPkg::halted)
			else failCheck($sformatf("ended in %s, not fetchStart", state.name()));
		assert (writeCount == expWrites)
			else failCheck($sformatf("WriteReg %0d cycles, expected %0d", writeCount, expWrites));
		assert (storeCount == expStores)
			else failCheck($sformatf("DMemWrite %0d cycles, expected %0d", storeCount, expStores));
	endtask

	initial begin
		void'($urandom(87));
		instruction = '0;
		Overflow = 1'b0;
		resetReq = 1'b0;
		repeat (4) begin
			@(negedge clk);
			checkOutputs(ctrlPkg::fetchStart);
		end
		wait (!Reset);

		planSeq(3, ctrlPkg::decode, ctrlPkg::addReg, ctrlPkg::writeAlu);
		runInstr(encode(isaPkg::funct7Add, 3'b000, newRd(), isaPkg::opRegType), 1, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::subReg, ctrlPkg::writeAlu);
		runInstr(encode(isaPkg::funct7Sub, 3'b000, newRd(), isaPkg::opRegType), 1, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::andReg, ctrlPkg::writeAlu);
		runInstr(encode(isaPkg::funct7Add, 3'b111, newRd(), isaPkg::opRegType), 1, 0);
		planSeq(2, ctrlPkg::decode, ctrlPkg::sltReg);
		runInstr(encode(isaPkg::funct7Add, 3'b010, newRd(), isaPkg::opRegType), 1, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::calcOffset, ctrlPkg::writeAlu);
		runInstr(encode(7'($urandom), 3'b000, newRd(), isaPkg::opImm), 1, 0);
		planSeq(2, ctrlPkg::decode, ctrlPkg::sltiImm);
		runInstr(encode(7'($urandom), 3'b010, newRd(), isaPkg::opImm), 1, 0);
		planSeq(1, ctrlPkg::decode); // addi to x0
		runInstr(encode(7'($urandom), 3'b000, 5'd0, isaPkg::opImm), 0, 0);
		planSeq(5, ctrlPkg::decode, ctrlPkg::calcOffset, ctrlPkg::memRead, ctrlPkg::memWait,
			ctrlPkg::loadWrite);
		runInstr(encode(7'($urandom), 3'b010, newRd(), isaPkg::opLoad), 1, 0);
		planSeq(5, ctrlPkg::decode, ctrlPkg::calcOffset, ctrlPkg::memRead, ctrlPkg::memWait,
			ctrlPkg::memWrite);
		runInstr(encode(7'($urandom), 3'b010, newRd(), isaPkg::opStore), 0, 1);
		planSeq(2, ctrlPkg::decode, ctrlPkg::luiWrite);
		runInstr(encode(7'($urandom), 3'($urandom), newRd(), isaPkg::opLui), 1, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::branchEq, ctrlPkg::branchWait);
		runInstr(encode(7'($urandom), 3'b000, newRd(), isaPkg::opBranchEq), 0, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::branchNe, ctrlPkg::branchWait);
		runInstr(encode(7'($urandom), 3'b001, newRd(), isaPkg::opBranch), 0, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::branchLt, ctrlPkg::branchWait);
		runInstr(encode(7'($urandom), 3'b100, newRd(), isaPkg::opBranch), 0, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::branchGe, ctrlPkg::branchWait);
		runInstr(encode(7'($urandom), 3'b101, newRd(), isaPkg::opBranch), 0, 0);
		planSeq(4, ctrlPkg::decode, ctrlPkg::jumpLink, ctrlPkg::jumpTarget, ctrlPkg::branchWait);
		runInstr(encode(7'($urandom), 3'($urandom), newRd(), isaPkg::opJal), 1, 0);
		planSeq(6, ctrlPkg::decode, ctrlPkg::jumpLink, ctrlPkg::jalrLoadReg, ctrlPkg::jalrCalc,
			ctrlPkg::jumpTarget, ctrlPkg::branchWait);
		runInstr(encode(7'($urandom), 3'b000, newRd(), isaPkg::opBranch), 1, 0);

		// shifts and an unknown opcode all trap
		planSeq(3, ctrlPkg::decode, ctrlPkg::illegalTrap, ctrlPkg::trapEnd);
		runInstr(encode(7'd0, 3'b001, newRd(), isaPkg::opImm), 0, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::illegalTrap, ctrlPkg::trapEnd);
		runInstr(encode(isaPkg::funct7Sub, 3'b101, newRd(), isaPkg::opRegType), 0, 0);
		planSeq(3, ctrlPkg::decode, ctrlPkg::illegalTrap, ctrlPkg::trapEnd);
		runInstr(encode(7'($urandom), 3'($urandom), newRd(), 7'b1111111), 0, 0);

		planSeq(4, ctrlPkg::decode, ctrlPkg::addReg, ctrlPkg::overflowTrap, ctrlPkg::trapEnd);
		runInstr(encode(isaPkg::funct7Add, 3'b000, newRd(), isaPkg::opRegType), 0, 0,
			ctrlPkg::addReg, 1'b1);
		planSeq(2, ctrlPkg::overflowTrap, ctrlPkg::trapEnd);
		runInstr(encode(isaPkg::funct7Add, 3'b000, newRd(), isaPkg::opRegType), 0, 0,
			ctrlPkg::fetchIncr, 1'b1);
		planSeq(6, ctrlPkg::decode, ctrlPkg::jumpLink, ctrlPkg::jalrLoadReg, ctrlPkg::jalrCalc,
			ctrlPkg::overflowTrap, ctrlPkg::trapEnd);
		runInstr(encode(7'($urandom), 3'b000, newRd(), isaPkg::opBranch), 1, 0,
			ctrlPkg::jalrCalc, 1'b1);
		planSeq(3, ctrlPkg::decode, ctrlPkg::addReg, ctrlPkg::writeAlu); // not checked there
		runInstr(encode(isaPkg::funct7Add, 3'b000, newRd(), isaPkg::opRegType), 1, 0,
			ctrlPkg::writeAlu, 1'b1);
		planSeq(5, ctrlPkg::decode, ctrlPkg::calcOffset, ctrlPkg::memRead, ctrlPkg::memWait,
			ctrlPkg::loadWrite);
		runInstr(encode(7'($urandom), 3'b010, newRd(), isaPkg::opLoad), 1, 0,
			ctrlPkg::memWait, 1'b1);

		planSeq(2, ctrlPkg::decode, ctrlPkg::halted);
		runInstr(encode(7'd0, 3'b000, 5'd0, isaPkg::opSystem), 0, 0);
		repeat (4) begin
			Overflow = ~Overflow;
			@(negedge clk);
			checkOutputs(ctrlPkg::halted);
			@(posedge clk);
			#2;
		end
		Overflow = 1'b0;
		resetReq = 1'b1;
		#1;
		checkOutputs(ctrlPkg::fetchStart);
		resetReq = 1'b0;
		wait (!Reset);
		planSeq(3, ctrlPkg::decode, ctrlPkg::addReg, ctrlPkg::writeAlu);
		runInstr(encode(isaPkg::funct7Add, 3'b000, newRd(), isaPkg::opRegType), 1, 0);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int periodNs = 40,
	parameter int resetCycles = 8
) (
	input logic resetReq,
	output logic clk,
	output logic Reset
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	initial begin
		Reset = 1'b1;
		forever begin
			repeat (resetCycles) @(posedge clk);
			#2 Reset = 1'b0; // released off the edge
			@(posedge resetReq);
			Reset = 1'b1; // async, takes effect at once
		end
	end

endmodule

`default_nettype wire
